/* design/eeprom_pkg.sv */
package eeprom_pkg;

    typedef logic [10:0] eeprom_addr_t;     // byte address, 2048 bytes
    typedef logic [7:0]  byte_t;

    localparam logic [3:0] DEV_TYPE         = 4'b1010;
    localparam int         QUARTERS_PER_BIT = 4;
    localparam logic [1:0] LAST_QUARTER     = 2'(QUARTERS_PER_BIT - 1);
    localparam logic [1:0] SAMPLE_QUARTER   = 2'd2;  // second scl high quarter
    localparam logic [3:0] ACK_BIT          = 4'd8;  // ninth bit of a byte op

    typedef struct packed {
        logic         write;
        eeprom_addr_t addr;
        byte_t        wdata;
    } eeprom_req_t;

    typedef enum logic [1:0] {OP_START, OP_WRITE, OP_READ, OP_STOP} op_kind_t;

    typedef struct packed {
        op_kind_t kind;
        byte_t    data;
        logic     last;   // read only, send no-ack
    } i2c_op_t;

    typedef struct packed {
        op_kind_t kind;
        logic     nack;
        byte_t    rdata;
    } bit_done_t;

    typedef struct packed {
        byte_t rdata;
        logic  nack;
    } eeprom_resp_t;

    typedef enum logic [3:0] {
        D_IDLE, D_START, D_CTRL, D_ADDR, D_DATA,
        D_RESTART, D_CTRL_RD, D_READ, D_STOP, D_WAIT
    } decode_state_t;

    typedef enum logic [1:0] {E_IDLE, E_START, E_BYTE, E_STOP} engine_state_t;

endpackage

/* design/eeprom_cmd_decode.sv */
`timescale 1ns/1ns

module eeprom_cmd_decode import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  eeprom_req_t req,
    input  logic        req_valid,
    output logic        req_ready,
    output i2c_op_t     op,
    output logic        op_valid,
    input  logic        op_ready,
    input  logic        done_valid,
    input  logic        txn_free
);

    decode_state_t state;
    decode_state_t state_nxt;
    eeprom_req_t   cur_req;

    assign req_ready = (state == D_IDLE);

    // sequence step after the current op completes
    always_comb
    begin
        case (state)
            D_START:   state_nxt = D_CTRL;
            D_CTRL:    state_nxt = D_ADDR;
            D_ADDR:    state_nxt = cur_req.write ? D_DATA : D_RESTART;
            D_DATA:    state_nxt = D_STOP;
            D_RESTART: state_nxt = D_CTRL_RD;
            D_CTRL_RD: state_nxt = D_READ;
            D_READ:    state_nxt = D_STOP;
            D_STOP:    state_nxt = D_WAIT;
            default:   state_nxt = state;
        endcase
    end

    always_comb
    begin
        op.kind = OP_STOP;
        op.data = '0;
        op.last = 1'b0;
        case (state)
            D_START, D_RESTART: op.kind = OP_START;
            D_CTRL:
            begin
                op.kind = OP_WRITE;
                op.data = {DEV_TYPE, cur_req.addr[10:8], 1'b0};
            end
            D_ADDR:
            begin
                op.kind = OP_WRITE;
                op.data = cur_req.addr[7:0];
            end
            D_DATA:
            begin
                op.kind = OP_WRITE;
                op.data = cur_req.wdata;
            end
            D_CTRL_RD:
            begin
                op.kind = OP_WRITE;
                op.data = {DEV_TYPE, cur_req.addr[10:8], 1'b1};
            end
            D_READ:
            begin
                op.kind = OP_READ;
                op.last = 1'b1;   // single byte, closing no-ack
            end
            default: op.kind = OP_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= D_IDLE;
            op_valid <= 1'b0;
        end
        else
        begin
            if (op_valid && op_ready)
                op_valid <= 1'b0;
            if (state == D_IDLE && req_valid)
            begin
                state    <= D_START;
                op_valid <= 1'b1;
            end
            else if (state == D_WAIT && txn_free)
                state <= D_IDLE;
            else if (done_valid)
            begin
                state    <= state_nxt;
                op_valid <= (state_nxt != D_WAIT);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
            cur_req <= req;
    end

endmodule

/* design/i2c_bit_engine.sv */
`timescale 1ns/1ns

module i2c_bit_engine import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  i2c_op_t   op,
    input  logic      op_valid,
    output logic      op_ready,
    output bit_done_t done,
    output logic      done_valid,
    output logic      scl,
    output logic      sda_oe,
    input  logic      sda_in
);

    engine_state_t state;
    logic [1:0]    quarter;
    logic [3:0]    bit_cnt;     // 0..7 data, 8 ack
    op_kind_t      cur_kind;
    logic          cur_last;
    byte_t         tx_sh;
    byte_t         rx_sh;
    logic          ack_missing;
    logic          scl_nxt;
    logic          oe_nxt;
    logic          bit_oe;
    logic          last_q;

    assign op_ready = (state == E_IDLE);
    assign last_q   = (quarter == LAST_QUARTER);

    assign done.kind  = cur_kind;
    assign done.nack  = ack_missing;
    assign done.rdata = rx_sh;

    // level to drive for the current bit, ack included
    always_comb
    begin
        if (bit_cnt == ACK_BIT)
            bit_oe = (cur_kind == OP_READ) && !cur_last;
        else
            bit_oe = (cur_kind == OP_WRITE) && !tx_sh[7];
    end

    // bus levels per quarter
    always_comb
    begin
        scl_nxt = scl;
        oe_nxt  = sda_oe;
        case (state)
            E_START:
            begin
                scl_nxt = (quarter == 2'd1) || (quarter == 2'd2);
                oe_nxt  = quarter[1];       // falls with scl high
            end
            E_STOP:
            begin
                scl_nxt = (quarter != 2'd0);
                oe_nxt  = !quarter[1];      // released with scl high
            end
            E_BYTE:
            begin
                scl_nxt = (quarter == 2'd1) || (quarter == 2'd2);
                if (quarter == 2'd0)
                    oe_nxt = bit_oe;        // data moves only with scl low
            end
            default:
            begin
                scl_nxt = scl;
                oe_nxt  = sda_oe;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= E_IDLE;
            quarter    <= '0;
            bit_cnt    <= '0;
            scl        <= 1'b1;
            sda_oe     <= 1'b0;
            done_valid <= 1'b0;
        end
        else
        begin
            done_valid <= 1'b0;
            scl        <= scl_nxt;
            sda_oe     <= oe_nxt;
            if (state == E_IDLE)
            begin
                quarter <= '0;
                bit_cnt <= '0;
                if (op_valid)
                begin
                    case (op.kind)
                        OP_START: state <= E_START;
                        OP_STOP:  state <= E_STOP;
                        default:  state <= E_BYTE;
                    endcase
                end
            end
            else
            begin
                quarter <= quarter + 2'd1;
                if (last_q)
                begin
                    if (state == E_BYTE && bit_cnt != ACK_BIT)
                        bit_cnt <= bit_cnt + 4'd1;
                    else
                    begin
                        state      <= E_IDLE;
                        done_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (op_valid && op_ready)
        begin
            cur_kind    <= op.kind;
            cur_last    <= op.last;
            tx_sh       <= op.data;
            ack_missing <= 1'b0;
        end
        else if (state == E_BYTE)
        begin
            if (quarter == SAMPLE_QUARTER)
            begin
                if (bit_cnt == ACK_BIT)
                    ack_missing <= (cur_kind == OP_WRITE) && sda_in;
                else
                    rx_sh <= {rx_sh[6:0], sda_in};  // msb first
            end
            if (last_q)
                tx_sh <= {tx_sh[6:0], 1'b0};
        end
    end

endmodule

/* design/eeprom_result.sv */
`timescale 1ns/1ns

module eeprom_result import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  bit_done_t    done,
    input  logic         done_valid,
    output eeprom_resp_t resp,
    output logic         resp_valid,
    input  logic         resp_ready,
    output logic         txn_free
);

    logic  after_stop;   // next start opens a new transaction
    logic  nack_acc;
    byte_t rdata_acc;
    logic  fresh_start;

    assign fresh_start = done_valid && done.kind == OP_START && after_stop;
    assign txn_free    = resp_valid && resp_ready;
    assign resp.rdata  = rdata_acc;
    assign resp.nack   = nack_acc;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            resp_valid <= 1'b0;
            after_stop <= 1'b1;
            nack_acc   <= 1'b0;
        end
        else
        begin
            if (txn_free)
                resp_valid <= 1'b0;
            if (fresh_start)
            begin
                after_stop <= 1'b0;
                nack_acc   <= 1'b0;
            end
            else if (done_valid && done.kind == OP_WRITE)
                nack_acc <= nack_acc | done.nack;
            else if (done_valid && done.kind == OP_STOP)
            begin
                after_stop <= 1'b1;
                resp_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (fresh_start)
            rdata_acc <= '0;   // writes report zero
        else if (done_valid && done.kind == OP_READ)
            rdata_acc <= done.rdata;
    end

endmodule

/* design/eeprom_ctrl.sv */
`timescale 1ns/1ns

module eeprom_ctrl import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  eeprom_req_t  req,
    input  logic         req_valid,
    output logic         req_ready,
    output eeprom_resp_t resp,
    output logic         resp_valid,
    input  logic         resp_ready,
    output logic         scl,
    output logic         sda_oe,
    input  logic         sda_in
);

    i2c_op_t   op;
    logic      op_valid;
    logic      op_ready;
    bit_done_t done;
    logic      done_valid;
    logic      txn_free;

    eeprom_cmd_decode u_decode (
        .CLK        (CLK),
        .RESET      (RESET),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .op         (op),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .done_valid (done_valid),
        .txn_free   (txn_free)
    );

    i2c_bit_engine u_engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .op         (op),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .done       (done),
        .done_valid (done_valid),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

    eeprom_result u_result (
        .CLK        (CLK),
        .RESET      (RESET),
        .done       (done),
        .done_valid (done_valid),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .txn_free   (txn_free)
    );

endmodule

/* testbench/eeprom_slave_model.sv */
`timescale 1ns/1ns

module eeprom_slave_model
(
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic refuse,      // no acknowledge to anything
    output logic sda_oe,
    output int   protocol_errors
);

    logic [7:0]  mem [2048];
    logic        scl_q;
    logic        sda_q;
    logic        started;
    logic        reading;
    logic        master_ack;
    logic [3:0]  bit_cnt;     // 8 after the last data bit, 9 after ack
    logic [1:0]  byte_idx;    // control, word address, data
    logic [2:0]  block;
    logic [10:0] ptr;
    logic [7:0]  shreg;
    logic [7:0]  tx;

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (RESET)
        begin
            for (int a = 0; a < 2048; a++)
                mem[a] = 8'(a ^ (a >> 3));
            sda_oe          = 1'b0;
            started         = 1'b0;
            reading         = 1'b0;
            bit_cnt         = '0;
            byte_idx        = '0;
            ptr             = '0;
            protocol_errors = 0;
        end
        else if (scl && scl_q && sda != sda_q)
        begin
            if (!sda)
            begin
                // repeated start only right after the word address
                if (started && !(byte_idx == 2'd2 && bit_cnt <= 4'd1))
                begin
                    protocol_errors++;
                    $display("slave model: start condition in the middle of a transfer");
                end
                started  = 1'b1;
                reading  = 1'b0;
                bit_cnt  = '0;
                byte_idx = '0;
                shreg    = '0;
            end
            else
            begin
                if (!started)
                begin
                    protocol_errors++;
                    $display("slave model: stop condition without a start");
                end
                started = 1'b0;
                reading = 1'b0;
            end
        end
        else if (started && scl && !scl_q)
        begin
            if (bit_cnt < 4'd8)
            begin
                shreg   = {shreg[6:0], sda};
                bit_cnt = bit_cnt + 4'd1;
            end
            else
            begin
                master_ack = !sda;
                bit_cnt    = 4'd9;
            end
        end
        else if (started && !scl && scl_q)
        begin
            if (bit_cnt == 4'd8)
            begin
                sda_oe = 1'b0;
                if (!reading && !refuse)
                begin
                    sda_oe = 1'b1;    // ack
                    case (byte_idx)
                        2'd0:
                        begin
                            block   = shreg[3:1];
                            reading = shreg[0];
                            if (shreg[7:4] != 4'b1010)
                                sda_oe = 1'b0;
                        end
                        2'd1: ptr = {block, shreg};
                        default:
                        begin
                            mem[ptr] = shreg;
                            ptr      = ptr + 11'd1;
                        end
                    endcase
                end
                if (byte_idx != 2'd3)
                    byte_idx = byte_idx + 2'd1;
            end
            else if (bit_cnt == 4'd9)
            begin
                bit_cnt = '0;
                sda_oe  = 1'b0;
                if (reading && master_ack)
                begin
                    tx     = mem[ptr];
                    ptr    = ptr + 11'd1;
                    sda_oe = !tx[7];
                    tx     = {tx[6:0], 1'b0};
                end
            end
            else if (reading && bit_cnt != 4'd0)
            begin
                sda_oe = !tx[7];
                tx     = {tx[6:0], 1'b0};
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* testbench/eeprom_ctrl_props.sv */
`timescale 1ns/1ns

module eeprom_ctrl_props import eeprom_pkg::*;
(
    input logic         CLK,
    input logic         RESET,
    input eeprom_req_t  req,
    input logic         req_valid,
    input logic         req_ready,
    input eeprom_resp_t resp,
    input logic         resp_valid,
    input logic         resp_ready,
    input logic         scl,
    input logic         sda_oe,
    input op_kind_t     op_kind
);

    req_held: assert property (@(posedge CLK) disable iff (RESET)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else $error("request changed before it was taken");

    resp_held: assert property (@(posedge CLK) disable iff (RESET)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
        else $error("response changed before it was taken");

    // data line moves under high scl only for start and stop
    sda_quiet: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !$stable(sda_oe)) |-> (op_kind inside {OP_START, OP_STOP}))
        else $error("data line moved while scl was high during a byte");

endmodule

bind eeprom_ctrl eeprom_ctrl_props u_props (
    .CLK        (CLK),
    .RESET      (RESET),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .scl        (scl),
    .sda_oe     (sda_oe),
    .op_kind    (op.kind)
);

/* testbench/tb_eeprom_ctrl.sv */
`timescale 1ns/1ns

module tb_eeprom_ctrl import eeprom_pkg::*;
();

    localparam int NUM_REQ     = 60;
    localparam int CYCLE_LIMIT = NUM_REQ * 7 * 40 + 500;

    logic         CLK;
    logic         RESET;
    eeprom_req_t  req;
    logic         req_valid;
    logic         req_ready;
    eeprom_resp_t resp;
    logic         resp_valid;
    logic         resp_ready;
    logic         scl;
    logic         sda_oe;
    logic         slave_oe;
    logic         sda;
    logic         refuse;
    int           slave_errors;

    logic [31:0]  seed;
    int           errors;
    int           cycles;
    byte_t        model_mem [2048];
    eeprom_addr_t test_addr [8];

    assign sda = ~sda_oe & ~slave_oe;   // open-drain wired-AND

    eeprom_ctrl u_eeprom_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda)
    );

    eeprom_slave_model u_slave (
        .RESET           (RESET),
        .scl             (scl),
        .sda             (sda),
        .refuse          (refuse),
        .sda_oe          (slave_oe),
        .protocol_errors (slave_errors)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected)
        begin
            errors++;
            $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic check_idle_bus();
        compare("resp_valid", 32'(resp_valid), 32'd0);
        compare("req_ready", 32'(req_ready), 32'd1);
        compare("scl", 32'(scl), 32'd1);
        compare("sda", 32'(sda), 32'd1);
    endtask

    task automatic check_held(input eeprom_resp_t taken);
        compare("resp_valid", 32'(resp_valid), 32'd1);
        compare("resp", 32'(resp), 32'(taken));
        compare("req_ready", 32'(req_ready), 32'd0);
    endtask

    task automatic send_request(input logic wr, input eeprom_addr_t addr, input byte_t data);
        while (!req_ready)
            next_cycle();
        req.write = wr;
        req.addr  = addr;
        req.wdata = data;
        req_valid = 1'b1;
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic take_response(output eeprom_resp_t taken);
        int hold;
        while (!resp_valid)
            next_cycle();
        taken = resp;
        hold  = int'(next_rand() >> 30);   // 0..3 cycles of back-pressure
        compare("req_ready", 32'(req_ready), 32'd0);
        repeat (hold)
        begin
            next_cycle();
            check_held(taken);
        end
        resp_ready = 1'b1;
        next_cycle();
        resp_ready = 1'b0;
        check_idle_bus();
    endtask

    task automatic check_request(input logic wr, input eeprom_addr_t addr, input byte_t data,
                                 input logic no_ack);
        eeprom_resp_t r;
        byte_t        exp_rd;
        refuse = no_ack;
        send_request(wr, addr, data);
        take_response(r);
        compare("resp.nack", 32'(r.nack), 32'(no_ack));
        if (!wr)
        begin
            exp_rd = no_ack ? 8'hFF : model_mem[addr];   // released line reads ones
            compare("resp.rdata", 32'(r.rdata), 32'(exp_rd));
        end
        else if (!no_ack)
            model_mem[addr] = data;
        refuse = 1'b0;
    endtask

    // read waits behind an untaken write response
    task automatic check_queued_read(input eeprom_addr_t addr, input byte_t data);
        eeprom_resp_t r;
        send_request(1'b1, addr, data);
        while (!resp_valid)
            next_cycle();
        req.write = 1'b0;
        req.wdata = 8'h00;
        req_valid = 1'b1;
        take_response(r);
        next_cycle();
        req_valid = 1'b0;
        compare("resp.nack", 32'(r.nack), 32'd0);
        model_mem[addr] = data;
        take_response(r);
        compare("resp.nack", 32'(r.nack), 32'd0);
        compare("resp.rdata", 32'(r.rdata), 32'(model_mem[addr]));
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: no completion within %0d clock cycles", CYCLE_LIMIT);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0]  r;
        eeprom_addr_t a;
        seed       = 32'h38718006;
        errors     = 0;
        RESET      = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        refuse     = 1'b0;
        for (int i = 0; i < 2048; i++)
            model_mem[i] = 8'(i ^ (i >> 3));
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        check_idle_bus();
        compare("sda_oe", 32'(sda_oe), 32'd0);
        compare("op_valid", 32'(u_eeprom_ctrl.op_valid), 32'd0);

        // one write per block, then read back
        for (int i = 0; i < 8; i++)
        begin
            r            = next_rand();
            test_addr[i] = {3'(i), r[27:20]};
            check_request(1'b1, test_addr[i], r[31:24], 1'b0);
        end
        for (int i = 0; i < 8; i++)
            check_request(1'b0, test_addr[i], 8'h00, 1'b0);

        // small address pool so reads hit earlier writes
        for (int i = 0; i < 30; i++)
        begin
            r = next_rand();
            a = {r[30:28], 6'b0, r[21:20]};
            check_request(r[31], a, r[15:8] ^ r[27:20], 1'b0);
        end

        r = next_rand();
        check_queued_read(test_addr[5], r[23:16]);

        check_request(1'b1, test_addr[3], ~model_mem[test_addr[3]], 1'b1);
        check_request(1'b0, test_addr[3], 8'h00, 1'b1);
        check_request(1'b0, test_addr[3], 8'h00, 1'b0);   // refused write left no trace

        $display("errors: %0d check mismatches, %0d bus protocol faults",
                 errors, slave_errors);
        if (errors == 0 && slave_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* eeprom_ctrl.f */
design/eeprom_pkg.sv
design/eeprom_cmd_decode.sv
design/i2c_bit_engine.sv
design/eeprom_result.sv
design/eeprom_ctrl.sv
testbench/eeprom_slave_model.sv
testbench/eeprom_ctrl_props.sv
testbench/tb_eeprom_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the eeprom_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_eeprom_ctrl -f eeprom_ctrl.f -o sim_eeprom_ctrl

./obj_dir/sim_eeprom_ctrl | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log || ! grep -q "Simulation finished: PASS" sim.log
then
    echo "run failed"
    exit 1
fi
echo "run passed"
